// ==== lsu_stim.txt ====
// opcode address store_data expected_result, all hex, memory starts at zero
// opcodes 0 LB, 1 LH, 2 LW, 3 LBU, 4 LHU, 5 SB, 6 SH, 7 SW
7 00000100 8899AABB 00000000
2 00000100 00000000 8899AABB
0 00000101 00000000 FFFFFFAA
3 00000101 00000000 000000AA
1 00000102 00000000 FFFF8899
4 00000100 00000000 0000AABB
5 00000104 0000007F 00000000
6 00000106 00001234 00000000
2 00000104 00000000 1234007F
1 00000106 00000000 00001234
7 0000010A CAFEF00D 00000000
6 0000010F 00005A6B 00000000
2 0000010A 00000000 CAFEF00D
2 00000108 00000000 F00D0000
2 0000010C 00000000 6B00CAFE
1 0000010F 00000000 00005A6B
2 0000010D 00000000 5A6B00CA
0 0000010B 00000000 FFFFFFF0
4 0000010B 00000000 0000FEF0
1 0000010B 00000000 FFFFFEF0
5 00000103 00000011 00000000
2 00000100 00000000 1199AABB

// ==== compile.f ====
lsu_pkg.sv
lsu_ctrl_fsm.sv
lsu_trans_counter.sv
lsu_store_align.sv
lsu_load_align.sv
lsu_top.sv
tb_obi_mem.sv
tb_lsu.sv

// ==== tb_lsu.sv ====
`timescale 1ns/1ns

module tb_lsu;

  localparam int MAX_INSTR        = 64;
  localparam int CYCLES_PER_INSTR = 40;

  logic                               clk;
  logic                               rst_n;
  logic                               valid;
  lsu_pkg::lsu_op_e                   op;
  logic [lsu_pkg::ADDR_W-1:0]         addr;
  logic [lsu_pkg::DATA_W-1:0]         wdata;
  logic                               ready;
  logic                               resp_valid;
  logic [lsu_pkg::DATA_W-1:0]         resp_rdata;
  logic                               busy;
  logic                               bus_req;
  logic                               bus_gnt;
  logic [lsu_pkg::ADDR_W-1:0]         bus_addr;
  logic                               bus_we;
  logic [lsu_pkg::BE_W-1:0]           bus_be;
  logic [lsu_pkg::DATA_W-1:0]         bus_wdata;
  logic                               bus_rvalid;
  logic [lsu_pkg::DATA_W-1:0]         bus_rdata;

  // Four words per instruction: opcode, address, store data, expected result
  logic [31:0] stim [4*MAX_INSTR];
  logic [31:0] exp_q [$];
  int          n_instr;
  int          n_resp;
  int          errors;
  int          outstanding;
  logic [31:0] rnd;
  logic        hold_prev;
  logic [31:0] prev_addr;
  logic [31:0] prev_wdata;
  logic [3:0]  prev_be;

  always #2 clk = ~clk;

  lsu_top i_lsu_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_i      (valid),
    .op_i         (op),
    .addr_i       (addr),
    .wdata_i      (wdata),
    .ready_o      (ready),
    .resp_valid_o (resp_valid),
    .resp_rdata_o (resp_rdata),
    .busy_o       (busy),
    .bus_req_o    (bus_req),
    .bus_gnt_i    (bus_gnt),
    .bus_addr_o   (bus_addr),
    .bus_we_o     (bus_we),
    .bus_be_o     (bus_be),
    .bus_wdata_o  (bus_wdata),
    .bus_rvalid_i (bus_rvalid),
    .bus_rdata_i  (bus_rdata)
  );

  tb_obi_mem i_mem (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (bus_req),
    .addr_i   (bus_addr),
    .we_i     (bus_we),
    .be_i     (bus_be),
    .wdata_i  (bus_wdata),
    .gnt_o    (bus_gnt),
    .rvalid_o (bus_rvalid),
    .rdata_o  (bus_rdata)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  ////////////////////
  // Monitors
  ////////////////////

  // Responses come back in issue order, checked where everything is stable
  always @(negedge clk) begin : response_check
    logic [31:0] exp_v;
    if (rst_n && resp_valid) begin
      if (exp_q.size() == 0) begin
        $display("Response pulse at %0t with no instruction waiting for it", $time);
        errors++;
      end else begin
        exp_v = exp_q.pop_front();
        n_resp++;
        if (resp_rdata !== exp_v) begin
          $display("FAILED %0t: response %0d expected %h got %h", $time, n_resp, exp_v,
                   resp_rdata);
          errors++;
        end
      end
    end
  end

  // Address phase stability and the count of transfers in flight
  always @(negedge clk) begin : bus_check
    if (!rst_n) begin
      outstanding = 0;
      hold_prev   = 1'b0;
    end else begin
      if (hold_prev) begin
        if (!bus_req || bus_addr !== prev_addr || bus_be !== prev_be
            || bus_wdata !== prev_wdata) begin
          $display("FAILED %0t: address phase changed before grant, addr %h -> %h", $time,
                   prev_addr, bus_addr);
          errors++;
        end
      end
      if (bus_req && bus_addr[1:0] != 2'b00) begin
        $display("FAILED %0t: bus address %h not word aligned", $time, bus_addr);
        errors++;
      end
      hold_prev  = bus_req && !bus_gnt;
      prev_addr  = bus_addr;
      prev_be    = bus_be;
      prev_wdata = bus_wdata;
      if (outstanding != 0 && !busy) begin
        $display("FAILED %0t: %0d transfers outstanding but busy is low", $time, outstanding);
        errors++;
      end
      if (bus_rvalid && outstanding == 0) begin
        $display("Bus response at %0t with no transfer outstanding", $time);
        errors++;
      end
      if (bus_req && bus_gnt) begin
        outstanding++;
      end
      if (bus_rvalid) begin
        outstanding--;
      end
      if (outstanding > 2) begin
        $display("FAILED %0t: %0d transfers outstanding, limit is two", $time, outstanding);
        errors++;
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin : main_flow
    int cnt;
    int gap;
    clk    = 1'b0;
    rst_n  = 1'b0;
    valid  = 1'b0;
    op     = lsu_pkg::LSU_LW;
    addr   = '0;
    wdata  = '0;
    errors = 0;
    n_resp = 0;
    rnd    = 32'h2410;
    cnt    = 0;
    $readmemh("lsu_stim.txt", stim);
    while (cnt < MAX_INSTR && !$isunknown(stim[4*cnt])) begin
      cnt++;
    end
    if (cnt == 0) begin
      $display("Stimulus file lsu_stim.txt holds no instructions");
      errors++;
    end
    n_instr = cnt;

    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    if (!ready || bus_req || resp_valid || busy) begin
      $display("FAILED %0t: after reset ready=%b req=%b resp_valid=%b busy=%b", $time,
               ready, bus_req, resp_valid, busy);
      errors++;
    end

    for (int i = 0; i < n_instr; i++) begin
      // Random idle gap of 0 to 3 cycles, inputs change 1 ns after the edge
      rnd = xorshift(rnd);
      gap = rnd % 4;
      @(posedge clk);
      #1;
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      valid = 1'b1;
      op    = lsu_pkg::lsu_op_e'(stim[4*i][2:0]);
      addr  = stim[4*i+1];
      wdata = stim[4*i+2];
      do begin
        @(negedge clk);
      end while (!ready);
      exp_q.push_back(stim[4*i+3]);
      @(posedge clk);
      #1;
      valid = 1'b0;
    end

    wait (n_resp == n_instr);
    // A few more cycles so a stray extra pulse is caught
    repeat (8) @(posedge clk);
    if (exp_q.size() != 0 || outstanding != 0) begin
      $display("Run ended with %0d responses missing and %0d bus transfers open",
               exp_q.size(), outstanding);
      errors++;
    end

    $display("Closing: %0d instructions, %0d responses, %0d errors", n_instr, n_resp, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog sized from the stimulus length
  initial begin : watchdog
    wait (n_instr > 0);
    repeat (n_instr * CYCLES_PER_INSTR) @(posedge clk);
    $display("Timeout after %0d cycles with %0d of %0d responses seen",
             n_instr * CYCLES_PER_INSTR, n_resp, n_instr);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== tb_obi_mem.sv ====
`timescale 1ns/1ns

module tb_obi_mem (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  input  logic        we_i,
  input  logic [3:0]  be_i,
  input  logic [31:0] wdata_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o
);

  // Byte wide storage covering the low kilobyte of the address space
  logic [7:0]  mem [1024];
  logic [31:0] rsp_data_q [$];
  int unsigned rsp_due_q [$];
  int unsigned cycle;
  int unsigned waited;
  int unsigned gnt_target;
  int unsigned last_due;
  logic [31:0] seed;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  initial begin
    for (int a = 0; a < 1024; a++) begin
      mem[a] = 8'h00;
    end
    gnt_o      = 1'b0;
    rvalid_o   = 1'b0;
    rdata_o    = '0;
    seed       = 32'h2410;
    cycle      = 0;
    waited     = 0;
    gnt_target = 0;
    last_due   = 0;
  end

  ////////////////////
  // Bus slave
  ////////////////////

  // Sample on the rising edge, drive the bus back 1 ns later
  always @(posedge clk) begin : serve
    logic [9:0]  base;
    logic [31:0] rd;
    int unsigned due;
    if (!rst_n) begin
      rsp_data_q.delete();
      rsp_due_q.delete();
      waited = 0;
      #1;
      gnt_o    = 1'b0;
      rvalid_o = 1'b0;
    end else begin
      cycle++;
      if (req_i && gnt_o) begin
        // Read before write, bytes written only where enabled
        base = {addr_i[9:2], 2'b00};
        for (int k = 0; k < 4; k++) begin
          rd[8*k +: 8] = mem[base + k];
          if (we_i && be_i[k]) begin
            mem[base + k] = wdata_i[8*k +: 8];
          end
        end
        rsp_data_q.push_back(rd);
        // Response 1 to 3 cycles after the grant, never overtaking an older one
        seed = xorshift(seed);
        due  = cycle + 1 + (seed % 3);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        rsp_due_q.push_back(due);
        seed       = xorshift(seed);
        gnt_target = seed % 4;
        waited     = 0;
      end else if (req_i) begin
        waited++;
      end
      #1;
      gnt_o = (waited >= gnt_target);
      // What is driven now is seen at the next edge
      if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle + 1) begin
        rvalid_o = 1'b1;
        rdata_o  = rsp_data_q.pop_front();
        void'(rsp_due_q.pop_front());
      end else begin
        rvalid_o = 1'b0;
        rdata_o  = '0;
      end
    end
  end

endmodule

// ==== lsu_top.sv ====
`timescale 1ns/1ns

module lsu_top (
  input  logic                         clk,
  input  logic                         rst_n,
  // Core side
  input  logic                         valid_i,
  input  lsu_pkg::lsu_op_e             op_i,
  input  logic [lsu_pkg::ADDR_W-1:0]   addr_i,
  input  logic [lsu_pkg::DATA_W-1:0]   wdata_i,
  output logic                         ready_o,
  output logic                         resp_valid_o,
  output logic [lsu_pkg::DATA_W-1:0]   resp_rdata_o,
  output logic                         busy_o,
  // Data bus
  output logic                         bus_req_o,
  input  logic                         bus_gnt_i,
  output logic [lsu_pkg::ADDR_W-1:0]   bus_addr_o,
  output logic                         bus_we_o,
  output logic [lsu_pkg::BE_W-1:0]     bus_be_o,
  output logic [lsu_pkg::DATA_W-1:0]   bus_wdata_o,
  input  logic                         bus_rvalid_i,
  input  logic [lsu_pkg::DATA_W-1:0]   bus_rdata_i
);

  logic                        accept;
  logic                        issue;
  logic                        issue_ok;
  logic                        split;
  logic                        second;
  lsu_pkg::lsu_op_e            op_q;
  logic [1:0]                  offset;
  logic [lsu_pkg::DATA_W-1:0]  wdata_q;

  // Controller owns the address phase, last_o is only checked inside it
  lsu_ctrl_fsm i_ctrl_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid_i    (valid_i),
    .op_i       (op_i),
    .addr_i     (addr_i),
    .wdata_i    (wdata_i),
    .bus_gnt_i  (bus_gnt_i),
    .issue_ok_i (issue_ok),
    .ready_o    (ready_o),
    .accept_o   (accept),
    .bus_req_o  (bus_req_o),
    .bus_addr_o (bus_addr_o),
    .bus_we_o   (bus_we_o),
    .op_q_o     (op_q),
    .offset_o   (offset),
    .second_o   (second),
    .wdata_q_o  (wdata_q),
    .issue_o    (issue),
    .split_o    (split),
    .last_o     ()
  );

  lsu_trans_counter i_trans_counter (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue_i      (issue),
    .bus_rvalid_i (bus_rvalid_i),
    .issue_ok_o   (issue_ok),
    .busy_o       (busy_o)
  );

  // Lane placement for the write data and the enables of both halves
  lsu_store_align i_store_align (
    .op_i     (op_q),
    .offset_i (offset),
    .second_i (second),
    .wdata_i  (wdata_q),
    .be_o     (bus_be_o),
    .wdata_o  (bus_wdata_o)
  );

  lsu_load_align i_load_align (
    .clk          (clk),
    .rst_n        (rst_n),
    .accept_i     (accept),
    .op_i         (op_q),
    .offset_i     (offset),
    .split_i      (split),
    .bus_rvalid_i (bus_rvalid_i),
    .bus_rdata_i  (bus_rdata_i),
    .resp_valid_o (resp_valid_o),
    .resp_rdata_o (resp_rdata_o)
  );

endmodule

// ==== lsu_load_align.sv ====
`timescale 1ns/1ns

module lsu_load_align (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         accept_i,
  input  lsu_pkg::lsu_op_e             op_i,
  input  logic [1:0]                   offset_i,
  input  logic                         split_i,
  input  logic                         bus_rvalid_i,
  input  logic [lsu_pkg::DATA_W-1:0]   bus_rdata_i,
  output logic                         resp_valid_o,
  output logic [lsu_pkg::DATA_W-1:0]   resp_rdata_o
);

  // Per-instruction info, one entry per instruction still waiting for its response
  lsu_pkg::lsu_op_e q_op    [lsu_pkg::MAX_OUTSTANDING];
  logic [1:0]       q_off   [lsu_pkg::MAX_OUTSTANDING];
  logic             q_split [lsu_pkg::MAX_OUTSTANDING];

  // Depth is a power of two so the pointers wrap on their own
  logic [$clog2(lsu_pkg::MAX_OUTSTANDING)-1:0]   wr_ptr_q;
  logic [$clog2(lsu_pkg::MAX_OUTSTANDING)-1:0]   rd_ptr_q;
  logic [$clog2(lsu_pkg::MAX_OUTSTANDING+1)-1:0] q_cnt_q;

  logic                          half_q;
  logic [lsu_pkg::DATA_W-1:0]    hold_q;
  logic                          resp_valid_q;
  logic [lsu_pkg::DATA_W-1:0]    resp_rdata_q;
  lsu_pkg::lsu_op_e              head_op;
  logic [1:0]                    head_off;
  logic                          head_split;
  logic                          final_rsp;
  logic [2*lsu_pkg::DATA_W-1:0]  joined;
  logic [2*lsu_pkg::DATA_W-1:0]  shifted;
  logic [lsu_pkg::DATA_W-1:0]    word;
  logic [lsu_pkg::DATA_W-1:0]    ext;

  assign head_op    = q_op[rd_ptr_q];
  assign head_off   = q_off[rd_ptr_q];
  assign head_split = q_split[rd_ptr_q];

  // Only the second response of a split finishes the instruction
  assign final_rsp = bus_rvalid_i && (!head_split || half_q);

  ////////////////////
  // Merge and extend
  ////////////////////

  always_comb begin
    // First word sits low, the spill-over word high
    joined  = head_split ? {bus_rdata_i, hold_q} : {{lsu_pkg::DATA_W{1'b0}}, bus_rdata_i};
    shifted = joined >> {head_off, 3'b000};
    word    = shifted[lsu_pkg::DATA_W-1:0];
    case (head_op)
      lsu_pkg::LSU_LB:  ext = {{(lsu_pkg::DATA_W-8){word[7]}}, word[7:0]};
      lsu_pkg::LSU_LH:  ext = {{(lsu_pkg::DATA_W-16){word[15]}}, word[15:0]};
      lsu_pkg::LSU_LW:  ext = word;
      lsu_pkg::LSU_LBU: ext = {{(lsu_pkg::DATA_W-8){1'b0}}, word[7:0]};
      lsu_pkg::LSU_LHU: ext = {{(lsu_pkg::DATA_W-16){1'b0}}, word[15:0]};
      // Stores answer with zero
      default:          ext = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      q_cnt_q      <= '0;
      half_q       <= 1'b0;
      resp_valid_q <= 1'b0;
    end else begin
      if (accept_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (final_rsp) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (accept_i && !final_rsp) begin
        q_cnt_q <= q_cnt_q + 1'b1;
      end else if (!accept_i && final_rsp) begin
        q_cnt_q <= q_cnt_q - 1'b1;
      end
      // Set by the first half of a split, cleared by the response that ends it
      if (bus_rvalid_i) begin
        half_q <= head_split && !half_q;
      end
      resp_valid_q <= final_rsp;
    end
  end

  always_ff @(posedge clk) begin
    if (accept_i) begin
      q_op[wr_ptr_q]    <= op_i;
      q_off[wr_ptr_q]   <= offset_i;
      q_split[wr_ptr_q] <= split_i;
    end
    if (bus_rvalid_i && !final_rsp) begin
      hold_q <= bus_rdata_i;
    end
    if (final_rsp) begin
      resp_rdata_q <= ext;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_rdata_o = resp_rdata_q;

  ////////////////////
  // Assertions
  ////////////////////

  a_queue_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
    accept_i && !final_rsp |-> (q_cnt_q < lsu_pkg::MAX_OUTSTANDING))
    else $error("Response queue overflow");

  a_queue_no_underflow : assert property (@(posedge clk) disable iff (!rst_n)
    bus_rvalid_i |-> (q_cnt_q != '0))
    else $error("Response with an empty queue");

endmodule

// ==== lsu_store_align.sv ====
`timescale 1ns/1ns

module lsu_store_align (
  input  lsu_pkg::lsu_op_e             op_i,
  input  logic [1:0]                   offset_i,
  input  logic                         second_i,
  input  logic [lsu_pkg::DATA_W-1:0]   wdata_i,
  output logic [lsu_pkg::BE_W-1:0]     be_o,
  output logic [lsu_pkg::DATA_W-1:0]   wdata_o
);

  logic [lsu_pkg::BE_W-1:0]     mask;
  logic [2*lsu_pkg::BE_W-1:0]   lanes;
  logic [2*lsu_pkg::DATA_W-1:0] doubled;

  // Byte mask of the access before it is moved to its offset
  always_comb begin
    case (lsu_pkg::op_size(op_i))
      2'd0:    mask = {{(lsu_pkg::BE_W-1){1'b0}}, 1'b1};
      2'd1:    mask = {{(lsu_pkg::BE_W-2){1'b0}}, 2'b11};
      default: mask = {lsu_pkg::BE_W{1'b1}};
    endcase
  end

  // Shifted over two words, the upper word holds the lanes that spill over
  assign lanes = {{lsu_pkg::BE_W{1'b0}}, mask} << offset_i;
  assign be_o  = second_i ? lanes[2*lsu_pkg::BE_W-1:lsu_pkg::BE_W]
                          : lanes[lsu_pkg::BE_W-1:0];

  // Rotate left by whole bytes
  // The same rotated word serves both halves since each half only enables its own lanes
  assign doubled = {wdata_i, wdata_i} << {offset_i, 3'b000};
  assign wdata_o = doubled[2*lsu_pkg::DATA_W-1:lsu_pkg::DATA_W];

endmodule

// ==== lsu_trans_counter.sv ====
`timescale 1ns/1ns

module lsu_trans_counter (
  input  logic clk,
  input  logic rst_n,
  input  logic issue_i,
  input  logic bus_rvalid_i,
  output logic issue_ok_o,
  output logic busy_o
);

  logic [$clog2(lsu_pkg::MAX_OUTSTANDING+1)-1:0] cnt_q;
  logic [$clog2(lsu_pkg::MAX_OUTSTANDING+1)-1:0] cnt_d;

  // Granted transfers count up, responses count down, both together cancel
  always_comb begin
    cnt_d = cnt_q;
    if (issue_i && !bus_rvalid_i) begin
      cnt_d = cnt_q + 1'b1;
    end else if (!issue_i && bus_rvalid_i) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // A retiring response frees a slot in the same cycle
  assign issue_ok_o = (cnt_q < lsu_pkg::MAX_OUTSTANDING) || bus_rvalid_i;
  assign busy_o     = (cnt_q != '0);

  ////////////////////
  // Assertions
  ////////////////////

  a_cnt_max : assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= lsu_pkg::MAX_OUTSTANDING)
    else $error("Outstanding transfer count above limit");

  a_cnt_no_underflow : assert property (@(posedge clk) disable iff (!rst_n)
    (cnt_q == '0) |=> (cnt_q <= 1))
    else $error("Outstanding transfer count underflow");

  a_no_spurious_rvalid : assert property (@(posedge clk) disable iff (!rst_n)
    bus_rvalid_i |-> (cnt_q != '0))
    else $error("Response without an outstanding transfer");

  // A granted transfer is outstanding from the next cycle on, so busy shows it
  a_busy_outstanding : assert property (@(posedge clk) disable iff (!rst_n)
    issue_i |=> busy_o)
    else $error("Transfer granted but busy is low");

endmodule

// ==== lsu_ctrl_fsm.sv ====
`timescale 1ns/1ns

module lsu_ctrl_fsm (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         valid_i,
  input  lsu_pkg::lsu_op_e             op_i,
  input  logic [lsu_pkg::ADDR_W-1:0]   addr_i,
  input  logic [lsu_pkg::DATA_W-1:0]   wdata_i,
  input  logic                         bus_gnt_i,
  input  logic                         issue_ok_i,
  output logic                         ready_o,
  output logic                         accept_o,
  output logic                         bus_req_o,
  output logic [lsu_pkg::ADDR_W-1:0]   bus_addr_o,
  output logic                         bus_we_o,
  output lsu_pkg::lsu_op_e             op_q_o,
  output logic [1:0]                   offset_o,
  output logic                         second_o,
  output logic [lsu_pkg::DATA_W-1:0]   wdata_q_o,
  output logic                         issue_o,
  output logic                         split_o,
  output logic                         last_o
);

  lsu_pkg::lsu_state_e               state_q;
  logic                              req_q;
  logic                              accept_q;
  logic                              split_q;
  logic                              we_q;
  lsu_pkg::lsu_op_e                  op_q;
  logic [1:0]                        offset_q;
  logic [lsu_pkg::ADDR_W-1:0]        addr_q;
  logic [lsu_pkg::DATA_W-1:0]        wdata_q;
  logic                              accept;
  logic [2:0]                        nbytes;
  logic                              split_new;

  ////////////////////
  // Handshakes
  ////////////////////

  // New work is taken only when idle and the counter has room for the first transfer
  assign ready_o = (state_q == lsu_pkg::LSU_IDLE) && issue_ok_i;
  assign accept  = valid_i && ready_o;

  // An access splits when its last byte falls past lane 3
  assign nbytes    = 3'd1 << lsu_pkg::op_size(op_i);
  assign split_new = ({1'b0, addr_i[1:0]} + nbytes) > 3'd4;

  // Hold the request back while the counter is full
  assign bus_req_o = req_q && issue_ok_i;
  assign issue_o   = bus_req_o && bus_gnt_i;
  assign last_o    = (state_q == lsu_pkg::LSU_SECOND) || !split_q;

  assign accept_o   = accept_q;
  assign split_o    = split_q;
  assign second_o   = (state_q == lsu_pkg::LSU_SECOND);
  assign bus_addr_o = addr_q;
  assign bus_we_o   = we_q;
  assign op_q_o     = op_q;
  assign offset_o   = offset_q;
  assign wdata_q_o  = wdata_q;

  ////////////////////
  // State register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= lsu_pkg::LSU_IDLE;
      req_q    <= 1'b0;
      accept_q <= 1'b0;
      split_q  <= 1'b0;
    end else begin
      // Load side queues the instruction one cycle after acceptance
      accept_q <= accept;
      case (state_q)
        lsu_pkg::LSU_IDLE: begin
          if (accept) begin
            state_q <= lsu_pkg::LSU_FIRST;
            req_q   <= 1'b1;
            split_q <= split_new;
          end
        end
        lsu_pkg::LSU_FIRST: begin
          // A split keeps the request up and moves straight on to the next word
          if (issue_o) begin
            if (split_q) begin
              state_q <= lsu_pkg::LSU_SECOND;
            end else begin
              state_q <= lsu_pkg::LSU_IDLE;
              req_q   <= 1'b0;
            end
          end
        end
        lsu_pkg::LSU_SECOND: begin
          if (issue_o) begin
            state_q <= lsu_pkg::LSU_IDLE;
            req_q   <= 1'b0;
          end
        end
        default: begin
          state_q <= lsu_pkg::LSU_IDLE;
          req_q   <= 1'b0;
        end
      endcase
    end
  end

  // Instruction fields, with the bus address always word aligned
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q     <= op_i;
      offset_q <= addr_i[1:0];
      addr_q   <= {addr_i[lsu_pkg::ADDR_W-1:2], 2'b00};
      wdata_q  <= wdata_i;
      we_q     <= lsu_pkg::op_is_store(op_i);
    end else if (issue_o && (state_q == lsu_pkg::LSU_FIRST) && split_q) begin
      // Second half goes to the following word
      addr_q[lsu_pkg::ADDR_W-1:2] <= addr_q[lsu_pkg::ADDR_W-1:2] + 1'b1;
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  a_addr_phase_known : assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_o |-> !$isunknown({bus_addr_o, bus_we_o, op_q_o, offset_o, second_o}))
    else $error("Address phase has X while requesting");

  // Everything that feeds the address phase stays put until the grant
  a_addr_phase_stable : assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_o && !bus_gnt_i |=> bus_req_o && $stable(bus_addr_o) && $stable(bus_we_o)
                                && $stable(second_o) && $stable(wdata_q_o))
    else $error("Address phase changed before grant");

  // An accepted instruction drops ready and requests on the next cycle
  a_accept_to_req : assert property (@(posedge clk) disable iff (!rst_n)
    valid_i && ready_o |=> bus_req_o && !ready_o)
    else $error("Acceptance not followed by a bus request");

  // The second half of a split follows the first grant directly, one word up
  a_split_back_to_back : assert property (@(posedge clk) disable iff (!rst_n)
    issue_o && !last_o |=> second_o && (bus_addr_o == $past(bus_addr_o) + 4))
    else $error("Split transfer not followed by its second half on the next word");

endmodule

// ==== lsu_pkg.sv ====
package lsu_pkg;

  ////////////////////
  // Bus geometry
  ////////////////////

  // Address and data widths of the data bus
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  // One byte enable per byte lane
  localparam int BE_W = 4;
  // Bus transfers that may be in flight at once, also the response queue depth
  localparam int MAX_OUTSTANDING = 2;

  ////////////////////
  // Types
  ////////////////////

  // Memory opcodes coming from the execute stage
  typedef enum logic [2:0] {
    LSU_LB  = 3'd0,
    LSU_LH  = 3'd1,
    LSU_LW  = 3'd2,
    LSU_LBU = 3'd3,
    LSU_LHU = 3'd4,
    LSU_SB  = 3'd5,
    LSU_SH  = 3'd6,
    LSU_SW  = 3'd7
  } lsu_op_e;

  // Controller states, one per address phase of a possibly split access
  typedef enum logic [1:0] {
    LSU_IDLE   = 2'd0,
    LSU_FIRST  = 2'd1,
    LSU_SECOND = 2'd2
  } lsu_state_e;

  // Access size as log2 of the byte count, so 0 is byte, 1 is half and 2 is word
  function automatic logic [1:0] op_size(input lsu_op_e op);
    case (op)
      LSU_LB, LSU_LBU, LSU_SB: op_size = 2'd0;
      LSU_LH, LSU_LHU, LSU_SH: op_size = 2'd1;
      default:                 op_size = 2'd2;
    endcase
  endfunction

  // Stores are the upper three opcodes
  function automatic logic op_is_store(input lsu_op_e op);
    op_is_store = (op == LSU_SB) || (op == LSU_SH) || (op == LSU_SW);
  endfunction

endpackage
